//--- ntm_algebra.f
+incdir+src
src/ntm_pkg.sv
src/scalar_multiplier.sv
src/scalar_adder.sv
src/accelerator_matrix_vector_product.sv
src/ntm_algebra_top.sv
tests/tb_ntm_algebra.sv

//--- run_sim.sh
#!/bin/sh
# Build the ntm_algebra testbench with Verilator, run it, judge the log

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "cannot enter the project root"
  exit 1
fi

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_ntm_algebra -f ntm_algebra.f \
  -Mdir "$BUILD_DIR" -o tb_ntm_algebra
if [ $? -ne 0 ]; then
  echo "FAIL: Verilator build did not complete"
  exit 1
fi

"./$BUILD_DIR/tb_ntm_algebra" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "FAIL: simulation exited with status $sim_status"
  exit 1
fi

# Verdict comes from the log alone
grep -q "^No errors$" "$LOG"
if [ $? -eq 0 ]; then
  echo "PASS"
  exit 0
else
  echo "FAIL: pass line not found in $LOG"
  exit 1
fi

//--- src/accelerator_matrix_vector_product.sv
/*
 * Matrix-vector product y = A*b, operand buffers and row sequencing
 * One multiplier and one adder shared over all element pairs
 */
`timescale 1ns/1ps
`include "ntm_defines.svh"

module accelerator_matrix_vector_product (
  input  logic            CLK,
  input  logic            RST,
  input  logic            START,
  input  ntm_pkg::index_t SIZE_A_I_IN,
  input  ntm_pkg::index_t SIZE_A_J_IN,
  input  logic            DATA_A_IN_ENABLE,
  input  ntm_pkg::data_t  DATA_A_IN,
  input  logic            DATA_B_IN_ENABLE,
  input  ntm_pkg::data_t  DATA_B_IN,
  output logic            READY,
  output logic            DATA_OUT_ENABLE,
  output ntm_pkg::data_t  DATA_OUT
);

  import ntm_pkg::*;

  // Buffer address width
  localparam int ADDR_W = $clog2(`MAX_DIM);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  mvp_state_t state;

  // Job sizes latched on START
  index_t size_i;
  index_t size_j;

  // Operand storage
  data_t a_buf [0:`MAX_DIM-1][0:`MAX_DIM-1];
  data_t b_buf [0:`MAX_DIM-1];

  // Write side, row-major for A
  index_t a_wr_row;
  index_t a_wr_col;
  index_t b_wr;
  logic a_loaded;
  logic b_loaded;
  logic a_wr_last_col;
  logic a_store;
  logic b_store;

  // Compute side
  index_t row;
  index_t col;
  logic last_row;
  logic last_col;
  data_t acc;

  // Multiplier handshake
  logic mul_start;
  logic mul_ready;
  data_t mul_a;
  data_t mul_b;
  data_t mul_out;

  // Adder handshake
  logic add_start;
  logic add_ready;
  data_t add_out;

  ////////////////////////////////////////
  // Load bookkeeping
  ////////////////////////////////////////

  assign a_loaded = (a_wr_row == size_i);
  assign b_loaded = (b_wr == size_j);
  assign a_wr_last_col = (index_t'(a_wr_col + 1'b1) == size_j);

  // Surplus enables fall through here
  assign a_store = (state == LOAD) && DATA_A_IN_ENABLE && !a_loaded;
  assign b_store = (state == LOAD) && DATA_B_IN_ENABLE && !b_loaded;

  always_ff @(posedge CLK) begin
    if (a_store) begin
      a_buf[a_wr_row[ADDR_W-1:0]][a_wr_col[ADDR_W-1:0]] <= DATA_A_IN;
    end
    if (b_store) begin
      b_buf[b_wr[ADDR_W-1:0]] <= DATA_B_IN;
    end
  end

  ////////////////////////////////////////
  // Operand selection
  ////////////////////////////////////////

  assign last_row = (index_t'(row + 1'b1) == size_i);
  assign last_col = (index_t'(col + 1'b1) == size_j);

  // Held stable for the whole multiply
  assign mul_a = a_buf[row[ADDR_W-1:0]][col[ADDR_W-1:0]];
  assign mul_b = b_buf[col[ADDR_W-1:0]];

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= IDLE;
      size_i          <= '0;
      size_j          <= '0;
      a_wr_row        <= '0;
      a_wr_col        <= '0;
      b_wr            <= '0;
      row             <= '0;
      col             <= '0;
      acc             <= '0;
      mul_start       <= 1'b0;
      add_start       <= 1'b0;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      DATA_OUT        <= '0;
    end else begin
      // Single-cycle pulses by default
      mul_start       <= 1'b0;
      add_start       <= 1'b0;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;

      case (state)
        IDLE: begin
          if (START) begin
            size_i   <= SIZE_A_I_IN;
            size_j   <= SIZE_A_J_IN;
            a_wr_row <= '0;
            a_wr_col <= '0;
            b_wr     <= '0;
            state    <= LOAD;
          end
        end

        LOAD: begin
          if (a_loaded && b_loaded) begin
            // First multiply issued on the way out
            row       <= '0;
            col       <= '0;
            acc       <= '0;
            mul_start <= 1'b1;
            state     <= MULTIPLY;
          end else begin
            if (a_store) begin
              if (a_wr_last_col) begin
                a_wr_col <= '0;
                a_wr_row <= a_wr_row + 1'b1;
              end else begin
                a_wr_col <= a_wr_col + 1'b1;
              end
            end
            if (b_store) begin
              b_wr <= b_wr + 1'b1;
            end
          end
        end

        MULTIPLY: begin
          // Product valid in the READY cycle
          if (mul_ready) begin
            add_start <= 1'b1;
            state     <= ACCUMULATE;
          end
        end

        ACCUMULATE: begin
          if (add_ready) begin
            acc <= add_out;
            if (last_col) begin
              DATA_OUT        <= add_out;
              DATA_OUT_ENABLE <= 1'b1;
              state           <= EMIT;
            end else begin
              col       <= col + 1'b1;
              mul_start <= 1'b1;
              state     <= MULTIPLY;
            end
          end
        end

        EMIT: begin
          // DATA_OUT_ENABLE high this cycle, fresh row next
          acc <= '0;
          col <= '0;
          if (last_row) begin
            READY <= 1'b1;
            state <= DONE;
          end else begin
            row       <= row + 1'b1;
            mul_start <= 1'b1;
            state     <= MULTIPLY;
          end
        end

        DONE: begin
          state <= IDLE;
        end

        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Arithmetic units
  ////////////////////////////////////////

  scalar_multiplier i_scalar_multiplier (
    .CLK      (CLK),
    .RST      (RST),
    .START    (mul_start),
    .DATA_A_IN(mul_a),
    .DATA_B_IN(mul_b),
    .READY    (mul_ready),
    .DATA_OUT (mul_out)
  );

  // Newest product plus running sum
  scalar_adder i_scalar_adder (
    .CLK      (CLK),
    .RST      (RST),
    .START    (add_start),
    .DATA_A_IN(mul_out),
    .DATA_B_IN(acc),
    .READY    (add_ready),
    .DATA_OUT (add_out)
  );

endmodule

//--- src/ntm_algebra_top.sv
/*
 * Linear algebra subsystem boundary around the matrix-vector product
 */
`timescale 1ns/1ps

module ntm_algebra_top (
  input  logic            CLK,
  input  logic            RST,
  input  logic            START,
  input  ntm_pkg::index_t SIZE_A_I_IN,
  input  ntm_pkg::index_t SIZE_A_J_IN,
  input  logic            DATA_A_IN_ENABLE,
  input  ntm_pkg::data_t  DATA_A_IN,
  input  logic            DATA_B_IN_ENABLE,
  input  ntm_pkg::data_t  DATA_B_IN,
  output logic            READY,
  output logic            DATA_OUT_ENABLE,
  output ntm_pkg::data_t  DATA_OUT
);

  // Host ports straight through, no extra pipeline stage
  accelerator_matrix_vector_product i_accelerator_matrix_vector_product (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .SIZE_A_I_IN     (SIZE_A_I_IN),
    .SIZE_A_J_IN     (SIZE_A_J_IN),
    .DATA_A_IN_ENABLE(DATA_A_IN_ENABLE),
    .DATA_A_IN       (DATA_A_IN),
    .DATA_B_IN_ENABLE(DATA_B_IN_ENABLE),
    .DATA_B_IN       (DATA_B_IN),
    .READY           (READY),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
    .DATA_OUT        (DATA_OUT)
  );

endmodule

//--- src/ntm_defines.svh
/*
 * Global sizing macros for the matrix-vector accelerator
 */
`ifndef NTM_DEFINES_SVH
`define NTM_DEFINES_SVH

////////////////////////////////////////
// Number format
////////////////////////////////////////

// Width of one signed data word
`define DATA_SIZE 16

// Fraction bits of the Q8.8 format
`define FRAC_SIZE 8

////////////////////////////////////////
// Problem size
////////////////////////////////////////

// Largest I and J accepted by the accelerator
`define MAX_DIM 4

`endif

//--- src/ntm_pkg.sv
/*
 * Shared types: data word, size index, control states, saturation limits
 */
`include "ntm_defines.svh"

package ntm_pkg;

  // Signed fixed point word, Q8.8
  typedef logic signed [`DATA_SIZE-1:0] data_t;

  // Wide enough to hold MAX_DIM itself
  typedef logic [$clog2(`MAX_DIM+1)-1:0] index_t;

  // Matrix-vector control FSM
  typedef enum logic [2:0] {
    IDLE,        // Waiting for START
    LOAD,        // Streaming A and b in
    MULTIPLY,    // Product of one element pair
    ACCUMULATE,  // Running sum of the row
    EMIT,        // Row result on DATA_OUT
    DONE         // READY pulse
  } mvp_state_t;

  ////////////////////////////////////////
  // Saturation limits
  ////////////////////////////////////////

  // Largest positive word, 0x7FFF
  localparam data_t DATA_MAX = {1'b0, {(`DATA_SIZE-1){1'b1}}};

  // Most negative word, 0x8000
  localparam data_t DATA_MIN = {1'b1, {(`DATA_SIZE-1){1'b0}}};

endpackage

//--- src/scalar_adder.sv
/*
 * Registered signed saturating adder, one cycle START to READY
 */
`timescale 1ns/1ps
`include "ntm_defines.svh"

module scalar_adder (
  input  logic           CLK,
  input  logic           RST,
  input  logic           START,
  input  ntm_pkg::data_t DATA_A_IN,
  input  ntm_pkg::data_t DATA_B_IN,
  output logic           READY,
  output ntm_pkg::data_t DATA_OUT
);

  import ntm_pkg::*;

  logic signed [`DATA_SIZE:0] sum_wide;
  logic overflow;
  data_t sum_sat;

  // Sign-extended sum, one guard bit
  assign sum_wide = {DATA_A_IN[`DATA_SIZE-1], DATA_A_IN}
                  + {DATA_B_IN[`DATA_SIZE-1], DATA_B_IN};

  // Guard and sign bit disagree on overflow
  assign overflow = sum_wide[`DATA_SIZE] ^ sum_wide[`DATA_SIZE-1];

  always_comb begin
    if (overflow) begin
      // Guard bit carries the true sign
      sum_sat = sum_wide[`DATA_SIZE] ? DATA_MIN : DATA_MAX;
    end else begin
      sum_sat = sum_wide[`DATA_SIZE-1:0];
    end
  end

  // Handshake, READY follows START by one cycle
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      READY <= 1'b0;
    end else begin
      READY <= START;
    end
  end

  always_ff @(posedge CLK) begin
    if (START) begin
      DATA_OUT <= sum_sat;
    end
  end

endmodule

//--- src/scalar_multiplier.sv
/*
 * Iterative signed fixed point multiplier
 * Shift-and-add on magnitudes, round half up, saturate
 */
`timescale 1ns/1ps
`include "ntm_defines.svh"

module scalar_multiplier (
  input  logic           CLK,
  input  logic           RST,
  input  logic           START,
  input  ntm_pkg::data_t DATA_A_IN,
  input  ntm_pkg::data_t DATA_B_IN,
  output logic           READY,
  output ntm_pkg::data_t DATA_OUT
);

  import ntm_pkg::*;

  localparam int PROD_W = 2 * `DATA_SIZE;
  localparam int CNT_W = $clog2(`DATA_SIZE);
  localparam int HALF_LSB = 1 << (`FRAC_SIZE - 1);

  // Control
  logic busy;
  logic [CNT_W-1:0] step_cnt;
  logic last_step;

  // Iteration registers
  logic neg;
  logic [PROD_W-1:0] mcand;
  logic [`DATA_SIZE-1:0] mplier;
  logic [PROD_W-1:0] prod;

  // Operand magnitudes
  logic [`DATA_SIZE-1:0] mag_a;
  logic [`DATA_SIZE-1:0] mag_b;

  // Final stage
  logic [PROD_W-1:0] prod_next;
  logic signed [PROD_W:0] prod_signed;
  logic signed [PROD_W:0] prod_round;
  logic signed [PROD_W:0] prod_shift;
  data_t result_sat;

  ////////////////////////////////////////
  // Combinational datapath
  ////////////////////////////////////////

  // Two's complement magnitude, 0x8000 stays 32768 unsigned
  assign mag_a = DATA_A_IN[`DATA_SIZE-1] ? ~DATA_A_IN + 1'b1 : DATA_A_IN;
  assign mag_b = DATA_B_IN[`DATA_SIZE-1] ? ~DATA_B_IN + 1'b1 : DATA_B_IN;

  assign last_step = (step_cnt == CNT_W'(`DATA_SIZE - 1));

  always_comb begin
    // One partial product per cycle, LSB of multiplier first
    prod_next = prod + (mplier[0] ? mcand : '0);

    // Sign back on, then round half up at the fraction point
    prod_signed = {1'b0, prod_next};
    if (neg) begin
      prod_signed = -prod_signed;
    end
    prod_round = prod_signed + HALF_LSB;
    prod_shift = prod_round >>> `FRAC_SIZE;

    // Clamp into the word range
    if (prod_shift > DATA_MAX) begin
      result_sat = DATA_MAX;
    end else if (prod_shift < DATA_MIN) begin
      result_sat = DATA_MIN;
    end else begin
      result_sat = prod_shift[`DATA_SIZE-1:0];
    end
  end

  ////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy     <= 1'b0;
      step_cnt <= '0;
      READY    <= 1'b0;
    end else begin
      READY <= 1'b0;
      if (busy) begin
        step_cnt <= step_cnt + 1'b1;
        if (last_step) begin
          busy  <= 1'b0;
          READY <= 1'b1;
        end
      end else if (START) begin
        busy     <= 1'b1;
        step_cnt <= '0;
      end
    end
  end

  // Operand capture and shift registers
  always_ff @(posedge CLK) begin
    if (!busy && START) begin
      mcand  <= {{`DATA_SIZE{1'b0}}, mag_a};
      mplier <= mag_b;
      prod   <= '0;
      neg    <= DATA_A_IN[`DATA_SIZE-1] ^ DATA_B_IN[`DATA_SIZE-1];
    end else if (busy) begin
      prod   <= prod_next;
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
      if (last_step) begin
        DATA_OUT <= result_sat;
      end
    end
  end

endmodule

//--- tests/tb_ntm_algebra.sv
/*
 * Testbench for ntm_algebra_top with a table of matrix-vector cases applied in a loop,
 * one LFSR random case with a Q8.8 reference model, timeout guard
 */
`timescale 1ns/1ps
`include "ntm_defines.svh"

module tb_ntm_algebra;

  import ntm_pkg::*;

  localparam int DW = `DATA_SIZE;
  localparam int MAX_ELEMS = `MAX_DIM * `MAX_DIM;
  localparam int NUM_TABLE = 7;
  localparam int NUM_CASES = NUM_TABLE + 1;
  // Worst case load and compute per case plus slack
  localparam int CYCLE_LIMIT = NUM_CASES * (2 * MAX_ELEMS + MAX_ELEMS * (DW + 4) + 50);
  // Offered on surplus enables and never stored
  localparam data_t JUNK = 16'h7ABC;

  ////////////////////////////////////////
  // DUT signals
  ////////////////////////////////////////

  logic CLK;
  logic RST;
  logic start;
  index_t size_i;
  index_t size_j;
  logic a_en;
  data_t a_data;
  logic b_en;
  data_t b_data;
  logic ready;
  logic out_en;
  data_t out_data;

  // Case table with elements packed in stream order and the first at the top
  int case_rows [NUM_CASES];
  int case_cols [NUM_CASES];
  logic [DW*MAX_ELEMS-1:0] case_a [NUM_CASES];
  logic [DW*`MAX_DIM-1:0] case_b [NUM_CASES];
  logic [DW*`MAX_DIM-1:0] case_y [NUM_CASES];
  // Two bits per cycle with bit 0 offering A and bit 1 offering b
  logic [31:0] case_gap [NUM_CASES];

  // Case being applied
  int cur_i;
  int cur_j;
  data_t cur_a [MAX_ELEMS];
  data_t cur_b [`MAX_DIM];
  data_t cur_y [`MAX_DIM];
  logic [31:0] cur_gap;

  logic [15:0] lfsr_state;
  int unsigned cycle_count = 0;

  ntm_algebra_top i_ntm_algebra_top (
    .CLK             (CLK),
    .RST             (RST),
    .START           (start),
    .SIZE_A_I_IN     (size_i),
    .SIZE_A_J_IN     (size_j),
    .DATA_A_IN_ENABLE(a_en),
    .DATA_A_IN       (a_data),
    .DATA_B_IN_ENABLE(b_en),
    .DATA_B_IN       (b_data),
    .READY           (ready),
    .DATA_OUT_ENABLE (out_en),
    .DATA_OUT        (out_data)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  ////////////////////////////////////////
  // Failure reporting
  ////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [DW-1:0] expected,
                             input logic [DW-1:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("mismatch at %0t: %s expected %0h, actual %0h",
                          $time, name, expected, actual));
    end
  endtask

  // Run guard
  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      abort_run($sformatf("timeout: no result or READY after %0d cycles", cycle_count));
    end
  end

  ////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////

  // Taps 16 14 13 11 for maximal length
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // One step per bit drawn
  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  function automatic data_t clamp_word(input longint v);
    if (v > longint'(DATA_MAX)) begin
      return DATA_MAX;
    end else if (v < longint'(DATA_MIN)) begin
      return DATA_MIN;
    end
    return data_t'(v);
  endfunction

  // Exact product plus half an LSB then a floor shift
  function automatic data_t model_mul(input data_t a, input data_t b);
    longint p;
    p = longint'(a) * longint'(b);
    p = (p + (longint'(1) << (`FRAC_SIZE - 1))) >>> `FRAC_SIZE;
    return clamp_word(p);
  endfunction

  function automatic data_t model_add(input data_t a, input data_t b);
    return clamp_word(longint'(a) + longint'(b));
  endfunction

  ////////////////////////////////////////
  // Case table
  ////////////////////////////////////////

  task automatic set_case(input int n, input int rows, input int cols,
                          input logic [DW*MAX_ELEMS-1:0] a, input logic [DW*`MAX_DIM-1:0] b,
                          input logic [DW*`MAX_DIM-1:0] y, input logic [31:0] gap);
    case_rows[n] = rows;
    case_cols[n] = cols;
    case_a[n] = a;
    case_b[n] = b;
    case_y[n] = y;
    case_gap[n] = gap;
  endtask

  task automatic build_table();
    // 2x2 whole numbers with A and b together every cycle
    set_case(0, 2, 2, {16'h0100, 16'h0200, 16'h0300, 16'h0400},
             {16'h0500, 16'h0600}, {16'h1100, 16'h2700}, 32'hFFFF_FFFF);
    // 3x4 whole numbers with negatives and alternating A and b
    set_case(1, 3, 4, {16'h0100, 16'h0000, 16'hFF00, 16'h0200,
                       16'h0200, 16'h0100, 16'h0000, 16'hFD00,
                       16'hFF00, 16'hFE00, 16'h0300, 16'h0100},
             {16'h0200, 16'h0300, 16'h0100, 16'hFF00},
             {16'hFF00, 16'h0A00, 16'hFA00}, 32'h9999_9999);
    // 1x1 product of 2.5 and -1.5
    set_case(2, 1, 1, {16'h0280}, {16'hFE80}, {16'hFC40}, 32'hFFFF_FFFF);
    // 4x1 column times one half with idle every other cycle
    set_case(3, 4, 1, {16'h0100, 16'h0200, 16'hFD00, 16'h0400}, {16'h0080},
             {16'h0080, 16'h0100, 16'hFE80, 16'h0200}, 32'h3333_3333);
    // 1x4 single row in bursts of two between gaps
    set_case(4, 1, 4, {16'h0100, 16'h0100, 16'h0100, 16'h0100},
             {16'h0100, 16'h0200, 16'h0300, 16'h0400}, {16'h0A00}, 32'hF0F0_F0F0);
    // Half LSB cases where a negative half rounds up to zero
    set_case(5, 3, 2, {16'h0001, 16'h0003, 16'hFFFF, 16'hFFFD, 16'h0180, 16'hFE40},
             {16'h0080, 16'h0040}, {16'h0002, 16'hFFFF, 16'h0050}, 32'h6666_6666);
    // Product saturation and a running sum that clamps mid row
    set_case(6, 3, 3, {16'h4000, 16'h0100, 16'h0200,
                       16'hC000, 16'hFF00, 16'h0000,
                       16'h1F00, 16'h7000, 16'h2000},
             {16'h0400, 16'h0100, 16'hFF00},
             {16'h7DFF, 16'h8000, 16'h5FFF}, 32'hC3C3_C3C3);
  endtask

  task automatic load_table_case(input int n);
    int na;
    na = case_rows[n] * case_cols[n];
    cur_i = case_rows[n];
    cur_j = case_cols[n];
    cur_gap = case_gap[n];
    for (int k = 0; k < na; k++) begin
      cur_a[k] = case_a[n][DW*(na-1-k) +: DW];
    end
    for (int k = 0; k < cur_j; k++) begin
      cur_b[k] = case_b[n][DW*(cur_j-1-k) +: DW];
    end
    for (int k = 0; k < cur_i; k++) begin
      cur_y[k] = case_y[n][DW*(cur_i-1-k) +: DW];
    end
  endtask

  // Operands within +-8.0 so some row sums clamp
  task automatic build_random_case();
    logic [31:0] r;
    data_t acc;
    draw_bits(2, r);
    cur_i = int'(r[1:0]) + 1;
    draw_bits(2, r);
    cur_j = int'(r[1:0]) + 1;
    for (int k = 0; k < cur_i * cur_j; k++) begin
      draw_bits(12, r);
      cur_a[k] = data_t'({{4{r[11]}}, r[11:0]});
    end
    for (int k = 0; k < cur_j; k++) begin
      draw_bits(12, r);
      cur_b[k] = data_t'({{4{r[11]}}, r[11:0]});
    end
    // Both offered at least every fourth cycle
    draw_bits(32, r);
    cur_gap = r | 32'h0303_0303;
    // Column order with a clamp at every step
    for (int row = 0; row < cur_i; row++) begin
      acc = '0;
      for (int col = 0; col < cur_j; col++) begin
        acc = model_add(acc, model_mul(cur_a[row*cur_j+col], cur_b[col]));
      end
      cur_y[row] = acc;
    end
  endtask

  ////////////////////////////////////////
  // Case sequence
  ////////////////////////////////////////

  task automatic run_case(input int n);
    int a_sent;
    int b_sent;
    int t;
    int rows_seen;
    logic [1:0] code;
    @(posedge CLK);
    start <= 1'b1;
    size_i <= index_t'(cur_i);
    size_j <= index_t'(cur_j);
    @(posedge CLK);
    start <= 1'b0;
    a_sent = 0;
    b_sent = 0;
    t = 0;
    // Streamed load where surplus enables carry junk
    while (a_sent < cur_i * cur_j || b_sent < cur_j) begin
      code = cur_gap[2*(t%16) +: 2];
      a_en <= code[0];
      b_en <= code[1];
      a_data <= (code[0] && a_sent < cur_i * cur_j) ? cur_a[a_sent] : JUNK;
      b_data <= (code[1] && b_sent < cur_j) ? cur_b[b_sent] : JUNK;
      if (code[0] && a_sent < cur_i * cur_j) begin
        a_sent++;
      end
      if (code[1] && b_sent < cur_j) begin
        b_sent++;
      end
      t++;
      @(posedge CLK);
    end
    a_en <= 1'b0;
    b_en <= 1'b0;
    // Stray START with other sizes while busy
    start <= 1'b1;
    size_i <= index_t'(1);
    size_j <= index_t'(1);
    rows_seen = 0;
    while (rows_seen < cur_i) begin
      @(negedge CLK);
      if (ready) begin
        abort_run($sformatf("case %0d: READY came before all row results", n));
      end
      if (out_en) begin
        check_value($sformatf("DATA_OUT row %0d", rows_seen), cur_y[rows_seen], out_data);
        rows_seen++;
      end
      @(posedge CLK);
      start <= 1'b0;
    end
    // One-cycle READY right after the last result
    @(negedge CLK);
    if (!ready) begin
      abort_run($sformatf("case %0d: READY did not follow the last row result", n));
    end
    check_value("DATA_OUT_ENABLE", 1'b0, out_en);
    @(negedge CLK);
    check_value("READY", 1'b0, ready);
    check_value("DATA_OUT_ENABLE", 1'b0, out_en);
    $display("case %0d: %0dx%0d done", n, cur_i, cur_j);
  endtask

  task automatic check_idle_outputs();
    check_value("READY", 1'b0, ready);
    check_value("DATA_OUT_ENABLE", 1'b0, out_en);
    check_value("DATA_OUT", '0, out_data);
  endtask

  initial begin
    RST = 1'b1;
    start = 1'b0;
    size_i = '0;
    size_j = '0;
    a_en = 1'b0;
    a_data = '0;
    b_en = 1'b0;
    b_data = '0;
    lfsr_state = 16'd64;
    build_table();
    // Quiet outputs through reset and up to the first START
    @(posedge CLK);
    repeat (7) begin
      @(negedge CLK);
      check_idle_outputs();
    end
    @(posedge CLK);
    RST <= 1'b0;
    repeat (4) begin
      @(negedge CLK);
      check_idle_outputs();
    end
    for (int n = 0; n < NUM_CASES; n++) begin
      if (n < NUM_TABLE) begin
        load_table_case(n);
      end else begin
        build_random_case();
      end
      run_case(n);
    end
    $display("No errors");
    $finish;
  end

endmodule
